//--- filelist.f
sprite_table_pkg.sv
sprite_write_decode.sv
sprite_entry_store.sv
sprite_hit_search.sv
sprite_read_select.sv
sprite_table_top.sv
tb_clock_gen.sv
tb_sprite_table.sv

//--- tb_sprite_table.sv
// sprite table testbench with stimulus, reference table and checking assertions
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_table import sprite_table_pkg::*; ();

	logic               clk;
	logic               rst;
	logic               written;
	logic [INDEX_W-1:0] n_reg;
	logic [1:0]         select_field;
	logic [WORD_W-1:0]  data;
	logic [CHECK_W-1:0] check;
	logic [WORD_W-1:0]  read_data;
	logic               success;

	logic [WORD_W-1:0]  model_mem [1:ENTRY_COUNT]; // mirror of entries 1 to 31
	logic [WORD_W-1:0]  exp_read;
	logic               exp_success;
	int                 error_count;
	int                 check_count;
	int                 test_base;

	tb_clock_gen i_clock_gen (
		.clk (clk),
		.rst (rst)
	);

	sprite_table_top i_dut (
		.clk          (clk),
		.rst          (rst),
		.written      (written),
		.n_reg        (n_reg),
		.select_field (select_field),
		.data         (data),
		.check        (check),
		.read_data    (read_data),
		.success      (success)
	);

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic logic [WORD_W-1:0] merged_word(input logic [WORD_W-1:0] old_word,
			input logic [1:0] field, input logic [WORD_W-1:0] bus);
		logic [WORD_W-1:0] w;
		w = old_word;
		case (field)
			2'd0: w[8:0]   = bus[8:0];   // offset
			2'd1: w[17:9]  = bus[17:9];  // y
			2'd2: w[26:18] = bus[26:18]; // x
			default: w = old_word;
		endcase
		return w;
	endfunction

	function automatic logic [WORD_W-1:0] expected_lookup(input logic [CHECK_W-1:0] query);
		int                qx;
		int                qy;
		int                ex;
		int                ey;
		logic [WORD_W-1:0] result;
		logic              found;
		qx     = query[17:9];
		qy     = query[8:0];
		result = MISS_WORD;
		found  = 1'b0;
		for (int i = 1; i <= ENTRY_COUNT; i++) begin
			ex = model_mem[i][26:18];
			ey = model_mem[i][17:9];
			if (!found && qx == ex && qy >= ey && qy <= ey + 19) begin // 20 lines, no wrap
				result = model_mem[i];
				found  = 1'b1;
			end
		end
		return result;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i <= ENTRY_COUNT; i++) begin
				model_mem[i] <= '0;
			end
			exp_read    <= MISS_WORD;
			exp_success <= 1'b0;
		end else begin
			exp_success <= written && (n_reg != 0) && (select_field != 2'd3);
			if (written && (n_reg != 0) && (select_field != 2'd3)) begin
				model_mem[n_reg] <= merged_word(model_mem[n_reg], select_field, data);
			end
			exp_read <= written ? MISS_WORD : expected_lookup(check); // old contents
		end
	end

	//////////////////////////////
	// checking assertions
	//////////////////////////////
	a_read_data: assert property (@(posedge clk) disable iff (rst) read_data === exp_read)
		check_count++;
	else begin
		error_count++;
		$display("Error: read_data expected %h got %h", $sampled(exp_read), $sampled(read_data));
	end

	a_success: assert property (@(posedge clk) disable iff (rst) success === exp_success)
		check_count++;
	else begin
		error_count++;
		$display("Error: success expected %h got %h", $sampled(exp_success), $sampled(success));
	end

	// a write cycle never reports a hit
	a_write_miss: assert property (@(posedge clk) disable iff (rst)
		written |=> (read_data === MISS_WORD))
		check_count++;
	else begin
		error_count++;
		$display("Error: read_data expected %h got %h after write cycle", MISS_WORD,
			$sampled(read_data));
	end

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////
	task automatic next_cycle();
		@(posedge clk);
		#1; // inputs move 1 ns after the edge
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst && cycles < 20) begin
			next_cycle();
			cycles++;
		end
		if (rst) begin
			error_count++;
			$display("reset was still asserted after %0d cycles", cycles);
		end
	endtask

	task automatic write_field(input int idx, input int field, input logic [8:0] value);
		logic [WORD_W-1:0] word;
		word = $urandom; // junk outside the slice
		case (field)
			FIELD_X: word[X_LSB +: COORD_W] = value;
			FIELD_Y: word[Y_LSB +: COORD_W] = value;
			default: word[OFFSET_LSB +: COORD_W] = value;
		endcase
		written      = 1'b1;
		n_reg        = INDEX_W'(idx);
		select_field = 2'(field);
		data         = word;
		next_cycle();
		written = 1'b0;
	endtask

	task automatic place_sprite(input int idx, input logic [8:0] x, input logic [8:0] y,
			input logic [8:0] off);
		write_field(idx, FIELD_X, x);
		write_field(idx, FIELD_Y, y);
		write_field(idx, FIELD_OFFSET, off);
	endtask

	task automatic query(input logic [8:0] x, input logic [8:0] y);
		written = 1'b0;
		check   = {x, y};
		next_cycle();
	endtask

	task automatic finish_test(input string name);
		next_cycle(); // let the last response be checked
		$display("test %s done, %0d errors", name, error_count - test_base);
		test_base = error_count;
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic reset_state();
		query(9'd0, 9'd5);  // zero entries cover x 0
		query(9'd5, 9'($urandom % 512));
		finish_test("reset_state");
	endtask

	task automatic field_writes();
		int          e;
		logic [8:0]  x;
		logic [8:0]  y;
		for (int k = 0; k < 4; k++) begin
			e = 1 + $urandom % ENTRY_COUNT;
			x = 9'(1 + $urandom % 511);
			y = 9'($urandom % 480);
			place_sprite(e, x, y, 9'($urandom));
			query(x, y + 9'($urandom % 20));
			write_field(e, FIELD_OFFSET, 9'($urandom)); // offset only
			query(x, y);
			x = 9'(1 + $urandom % 511);
			write_field(e, FIELD_X, x);
			query(x, y + 9'd19);
		end
		finish_test("field_writes");
	endtask

	task automatic success_rules();
		logic [8:0] x;
		x = 9'(1 + $urandom % 511);
		place_sprite(7, x, 9'd40, 9'h0a5);
		write_field(0, FIELD_X, 9'h1ff);  // entry 0 ignored
		query(x, 9'd45);
		write_field(7, 3, 9'h155);        // code 3 ignored
		query(x, 9'd45);
		write_field(7, FIELD_OFFSET, 9'h03c);
		query(x, 9'd45);
		query(x, 9'd50);
		finish_test("success_rules");
	endtask

	task automatic y_bounds();
		logic [8:0] x;
		logic [8:0] y;
		x = 9'(1 + $urandom % 511);
		y = 9'(1 + $urandom % 480);
		place_sprite(20, x, y, 9'($urandom));
		query(x, y);
		query(x, y + 9'd19);
		query(x, y + 9'd20);
		query(x, y - 9'd1);
		write_field(20, FIELD_Y, 9'd500); // top of the screen range
		query(x, 9'd511);
		query(x, 9'd499);
		finish_test("y_bounds");
	endtask

	task automatic entry_priority();
		logic [8:0] x;
		x = 9'(1 + $urandom % 511);
		place_sprite(9, x, 9'd100, 9'h011);
		place_sprite(3, x, 9'd110, 9'h022);
		query(x, 9'd115); // both cover, entry 3 wins
		query(x, 9'd105);
		query(x, 9'd125);
		finish_test("entry_priority");
	endtask

	task automatic write_cycle_miss();
		logic [8:0] x;
		x = 9'(1 + $urandom % 511);
		place_sprite(12, x, 9'd200, 9'h0f0);
		check = {x, 9'd205};              // matching query held during writes
		write_field(25, FIELD_OFFSET, 9'h12d);
		write_field(0, FIELD_Y, 9'h033);
		write_field(12, 3, 9'h077);
		query(x, 9'd205);
		finish_test("write_cycle_miss");
	endtask

	initial begin
		written      = 1'b0;
		n_reg        = '0;
		select_field = '0;
		data         = '0;
		check        = '0;
		error_count  = 0;
		check_count  = 0;
		test_base    = 0;
		void'($urandom(982));
		wait_reset_release();
		if (!rst) begin
			next_cycle();
			reset_state();
			field_writes();
			success_rules();
			y_bounds();
			entry_priority();
			write_cycle_miss();
		end
		next_cycle();
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock and reset source, 4 ns period with reset held for two cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk; // 4 ns period
		end
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0; // released off the edge like the other inputs
	end

endmodule

`default_nettype wire

//--- sprite_table_top.sv
// sprite coordinate table top level joining write decode, storage, search and read select
`timescale 1ns/1ps
`default_nettype none

module sprite_table_top import sprite_table_pkg::*; (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               written,
	input  wire logic [INDEX_W-1:0] n_reg,
	input  wire logic [1:0]         select_field,
	input  wire logic [WORD_W-1:0]  data,
	input  wire logic [CHECK_W-1:0] check,
	output logic [WORD_W-1:0]       read_data,
	output logic                    success
);

	//////////////////////////////
	// internal nets
	//////////////////////////////
	logic [ENTRY_COUNT-1:0]        entry_we; // one-hot, bit 0 is entry 1
	logic [FIELD_COUNT-1:0]        field_we;
	logic [ENTRY_COUNT*WORD_W-1:0] entries;  // flattened table contents
	logic [ENTRY_COUNT-1:0]        hit;

	//////////////////////////////
	// write path
	//////////////////////////////
	sprite_write_decode i_write_decode (
		.clk          (clk),
		.rst          (rst),
		.written      (written),
		.n_reg        (n_reg),
		.select_field (select_field),
		.entry_we     (entry_we),
		.field_we     (field_we),
		.success      (success)
	);

	sprite_entry_store i_entry_store (
		.clk      (clk),
		.rst      (rst),
		.entry_we (entry_we),
		.field_we (field_we),
		.data     (data),
		.entries  (entries)
	);

	//////////////////////////////
	// lookup path
	//////////////////////////////
	sprite_hit_search i_hit_search (
		.written (written),
		.check   (check),
		.entries (entries),
		.hit     (hit)
	);

	sprite_read_select i_read_select (
		.clk       (clk),
		.rst       (rst),
		.hit       (hit),
		.entries   (entries),
		.read_data (read_data)
	);

endmodule

`default_nettype wire

//--- sprite_read_select.sv
// priority pick of the lowest hitting entry and registered read word
`timescale 1ns/1ps
`default_nettype none

module sprite_read_select import sprite_table_pkg::*; (
	input  wire logic                            clk,
	input  wire logic                            rst,
	input  wire logic [ENTRY_COUNT-1:0]          hit,
	input  wire logic [ENTRY_COUNT*WORD_W-1:0]   entries,
	output logic [WORD_W-1:0]                    read_data
);

	logic [INDEX_W-1:0] hit_idx;
	logic [WORD_W-1:0]  hit_word;
	logic               any_hit;

	//////////////////////////////
	// priority encode
	//////////////////////////////
	always_comb begin
		hit_idx = '0;
		for (int i = ENTRY_COUNT - 1; i >= 0; i--) begin
			if (hit[i]) begin
				hit_idx = INDEX_W'(i); // lower index overrides, lowest entry wins
			end
		end
	end

	assign any_hit  = |hit;
	assign hit_word = entries[hit_idx*WORD_W +: WORD_W];

	//////////////////////////////
	// output register
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			read_data <= MISS_WORD;
		end else if (any_hit) begin
			read_data <= hit_word;
		end else begin
			read_data <= MISS_WORD; // nothing covers the query
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	a_reset_miss: assert property (@(posedge clk)
		rst |=> (read_data == MISS_WORD))
		else $error("read_data %h after reset, expected miss word", read_data);

endmodule

`default_nettype wire

//--- sprite_hit_search.sv
// parallel comparison of a lookup query against every sprite entry
`timescale 1ns/1ps
`default_nettype none

module sprite_hit_search import sprite_table_pkg::*; (
	input  wire logic                            written,
	input  wire logic [CHECK_W-1:0]              check,
	input  wire logic [ENTRY_COUNT*WORD_W-1:0]   entries,
	output logic [ENTRY_COUNT-1:0]               hit
);

	logic [COORD_W-1:0] qry_x;
	logic [COORD_W-1:0] qry_y;
	logic [COORD_W:0]   qry_y_ext;

	assign qry_x     = check[CHECK_W-1 -: COORD_W]; // x sits above y
	assign qry_y     = check[COORD_W-1:0];
	assign qry_y_ext = {1'b0, qry_y};

	//////////////////////////////
	// per-entry compare
	//////////////////////////////
	for (genvar g = 0; g < ENTRY_COUNT; g++) begin : g_cmp
		logic [COORD_W-1:0] ent_x;
		logic [COORD_W-1:0] ent_y;
		logic [COORD_W:0]   y_low;
		logic [COORD_W:0]   y_top;
		logic               x_match;
		logic               y_inside;

		assign ent_x = entries[g*WORD_W + X_LSB +: COORD_W];
		assign ent_y = entries[g*WORD_W + Y_LSB +: COORD_W];

		// 10-bit bounds so a sprite near line 511 does not wrap
		assign y_low = {1'b0, ent_y};
		assign y_top = y_low + (COORD_W+1)'(SPRITE_LINE - 1);

		assign x_match  = (qry_x == ent_x);
		assign y_inside = (qry_y_ext >= y_low) && (qry_y_ext <= y_top);

		assign hit[g] = !written && x_match && y_inside; // no lookup in a write cycle
	end

endmodule

`default_nettype wire

//--- sprite_entry_store.sv
// sprite entry storage with per-field updates of the 31 coordinate words
`timescale 1ns/1ps
`default_nettype none

module sprite_entry_store import sprite_table_pkg::*; (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire logic [ENTRY_COUNT-1:0]    entry_we,
	input  wire logic [FIELD_COUNT-1:0]    field_we,
	input  wire logic [WORD_W-1:0]         data,
	output logic [ENTRY_COUNT*WORD_W-1:0]  entries
);

	logic [WORD_W-1:0] field_mask; // bits of the enabled field

	//////////////////////////////
	// field slice
	//////////////////////////////
	always_comb begin
		field_mask = '0;
		if (field_we[FIELD_OFFSET]) begin
			field_mask[OFFSET_LSB +: COORD_W] = '1;
		end
		if (field_we[FIELD_Y]) begin
			field_mask[Y_LSB +: COORD_W] = '1;
		end
		if (field_we[FIELD_X]) begin
			field_mask[X_LSB +: COORD_W] = '1;
		end
	end

	//////////////////////////////
	// entry words
	//////////////////////////////
	for (genvar g = 0; g < ENTRY_COUNT; g++) begin : g_entry
		logic [WORD_W-1:0] word;

		always_ff @(posedge clk) begin
			if (rst) begin
				word <= '0;
			end else if (entry_we[g]) begin
				word <= (word & ~field_mask) | (data & field_mask); // other fields kept
			end
		end

		assign entries[g*WORD_W +: WORD_W] = word; // bit 0 is entry 1

		a_hold: assert property (@(posedge clk) disable iff (rst)
			!entry_we[g] |=> $stable(entries[g*WORD_W +: WORD_W]))
			else $error("entry %0d changed without write enable", g + 1);
	end

endmodule

`default_nettype wire

//--- sprite_write_decode.sv
// write request decoder producing one-hot entry and field enables and the success pulse
`timescale 1ns/1ps
`default_nettype none

module sprite_write_decode import sprite_table_pkg::*; (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               written,
	input  wire logic [INDEX_W-1:0] n_reg,
	input  wire logic [1:0]         select_field,
	output logic [ENTRY_COUNT-1:0]  entry_we,
	output logic [FIELD_COUNT-1:0]  field_we,
	output logic                    success
);

	logic write_ok;

	// entry 0 and field code 3 are not writable
	assign write_ok = written && (n_reg != '0) && (select_field < FIELD_COUNT);

	//////////////////////////////
	// one-hot expansion
	//////////////////////////////
	always_comb begin
		for (int i = 0; i < ENTRY_COUNT; i++) begin
			entry_we[i] = write_ok && (n_reg == INDEX_W'(i + 1)); // bit 0 is entry 1
		end
		for (int f = 0; f < FIELD_COUNT; f++) begin
			field_we[f] = write_ok && (select_field == 2'(f));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			success <= 1'b0;
		end else begin
			success <= write_ok; // one cycle per accepted write
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	a_we_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(entry_we) && $onehot0(field_we) && ((entry_we != '0) == (field_we != '0)))
		else $error("entry_we %h and field_we %h not paired one-hot", entry_we, field_we);

endmodule

`default_nettype wire

//--- sprite_table_pkg.sv
// sprite table package with word layout, field codes and lookup constants
`default_nettype none

package sprite_table_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////
	localparam int WORD_W      = 32; // entry word, data and read_data
	localparam int COORD_W     = 9;  // one coordinate or offset field
	localparam int ENTRY_COUNT = 31; // entries 1 to 31, no entry 0
	localparam int INDEX_W     = 5;  // n_reg width
	localparam int CHECK_W     = 18; // query word, x above y

	//////////////////////////////
	// field positions in a word
	//////////////////////////////
	localparam int OFFSET_LSB = 0;  // bits 8..0
	localparam int Y_LSB      = 9;  // bits 17..9
	localparam int X_LSB      = 18; // bits 26..18

	//////////////////////////////
	// select_field codes
	//////////////////////////////
	localparam int FIELD_OFFSET = 0;
	localparam int FIELD_Y      = 1;
	localparam int FIELD_X      = 2;
	localparam int FIELD_COUNT  = 3; // code 3 is not a field

	//////////////////////////////
	// lookup
	//////////////////////////////
	localparam int SPRITE_LINE = 20; // sprite height in lines

	// returned when no entry covers the query
	localparam logic [WORD_W-1:0] MISS_WORD = WORD_W'(1);

endpackage

`default_nettype wire
